//--- vlog.f
hdl/txt_pkg.sv
hdl/host_port.sv
hdl/scan_decode.sv
hdl/char_gen.sv
hdl/pixel_out.sv
hdl/text_display.sv
sim/tb_text_display.sv
sim/text_display_assertions.sv

//--- Makefile
# Verilator build and run for the text display testbench

SIM = obj_dir/Vtb_text_display

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TESTS PASSED" sim.log

$(SIM): vlog.f $(wildcard hdl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module tb_text_display -f vlog.f

clean:
	rm -rf obj_dir sim.log

//--- sim/text_display_assertions.sv
////////////////////////////////////////////////////////////
// Text display assertions
// Host handshake and video output rules
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module text_display_assertions (
  input wire             clk,
  input wire             rst_n,
  input wire             host_req,
  input wire             host_ack,
  input txt_pkg::video_t video
);

  ack_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(host_ack) |-> $past(host_req))
    else $error("host_ack rose without host_req");

  ack_fall_a: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(host_ack) |-> !$past(host_req))
    else $error("host_ack fell while host_req was high");

  // Sync pulses sit inside the blanking interval
  sync_blank_a: assert property (@(posedge clk) disable iff (!rst_n)
    (video.sync.hsync || video.sync.vsync) |-> video.sync.blank)
    else $error("sync active outside blanking");

  blank_color_a: assert property (@(posedge clk) disable iff (!rst_n)
    video.sync.blank |-> (video.color == 4'd0))
    else $error("nonzero color during blanking");

endmodule

bind text_display text_display_assertions u_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .host_req (host_req),
  .host_ack (host_ack),
  .video    (video)
);

`default_nettype wire

//--- sim/tb_text_display.sv
////////////////////////////////////////////////////////////
// Text display testbench
// Seeded host writes checked against a raster reference model
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_text_display;

  localparam int H_CHARS      = 4;
  localparam int V_CHARS      = 2;
  localparam int H_FRONT      = 2;
  localparam int H_SYNC       = 3;
  localparam int H_BACK       = 3;
  localparam int V_FRONT      = 2;
  localparam int V_SYNC       = 2;
  localparam int V_BACK       = 2;
  localparam int BLINK_FRAMES = 2;
  localparam int H_ACT = H_CHARS * txt_pkg::CHAR_W;
  localparam int H_TOT = H_ACT + H_FRONT + H_SYNC + H_BACK;
  localparam int V_ACT = V_CHARS * txt_pkg::CHAR_H;
  localparam int V_TOT = V_ACT + V_FRONT + V_SYNC + V_BACK;
  localparam int DRIVE_DLY     = 2;                    // ns after rising edge
  localparam int ACK_TIMEOUT   = 20;                   // Cycles
  localparam int FRAME_TIMEOUT = 8 * H_TOT * V_TOT;    // Cycles at half-rate pix_en
  localparam int N_FRAMES      = 8;
  localparam txt_pkg::video_t IDLE_VIDEO =
    '{color: 4'd0, sync: '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1}};

  logic clk = 1'b0;
  logic pix_en = 1'b0;
  logic rst_n;
  logic host_req;
  logic host_ack;
  txt_pkg::host_req_t host_cmd;
  txt_pkg::video_t    video;

  integer seed = 32'h43c54878;

  // Mirrors of what the host has written
  txt_pkg::cell_t screen_mirror [0:4095];
  logic [7:0]     font_mirror [0:4095];
  logic [7:0]     glyph_codes [0:7];

  int mx;
  int my;
  int mframe;
  txt_pkg::video_t exp_q [$];
  bit              full_q [$];                         // Color valid after load
  txt_pkg::video_t exp_old;
  bit              full_old;

  text_display #(
    .H_CHARS      (H_CHARS),
    .V_CHARS      (V_CHARS),
    .H_FRONT      (H_FRONT),
    .H_SYNC       (H_SYNC),
    .H_BACK       (H_BACK),
    .V_FRONT      (V_FRONT),
    .V_SYNC       (V_SYNC),
    .V_BACK       (V_BACK),
    .BLINK_FRAMES (BLINK_FRAMES)
  ) DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_en   (pix_en),
    .host_req (host_req),
    .host_cmd (host_cmd),
    .host_ack (host_ack),
    .video    (video)
  );

  always #20 clk = ~clk;

  // Pixel enable on alternate cycles
  always @(posedge clk) begin
    #DRIVE_DLY;
    pix_en = ~pix_en;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_video(input txt_pkg::video_t got, input txt_pkg::video_t exp);
    if (got !== exp) begin
      report_failure($sformatf(
        "error: time %0t: video got color %h sync %b, expected color %h sync %b",
        $time, got.color, got.sync, exp.color, exp.sync));
    end
  endtask

  task automatic check_sync(input txt_pkg::sync_t got, input txt_pkg::sync_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error: time %0t: sync got %b, expected %b (hsync vsync blank)",
                               $time, got, exp));
    end
  endtask

  // Expected output for one raster position
  function automatic txt_pkg::video_t expect_video(input int x, input int y, input int frame);
    txt_pkg::video_t v;
    txt_pkg::cell_t  c;
    logic [7:0]      bits;
    logic            pix;
    logic            blink_on;
    v.sync.hsync = (x >= H_ACT + H_FRONT) && (x < H_ACT + H_FRONT + H_SYNC);
    v.sync.vsync = (y >= V_ACT + V_FRONT) && (y < V_ACT + V_FRONT + V_SYNC);
    v.sync.blank = (x >= H_ACT) || (y >= V_ACT);
    v.color      = 4'd0;
    if (!v.sync.blank) begin
      c        = screen_mirror[12'((y / 16) * H_CHARS + x / 8)];
      bits     = font_mirror[{c.code, 4'(y % 16)}];
      pix      = bits[3'(7 - x % 8)];                 // Bit 7 leftmost
      blink_on = ((frame / BLINK_FRAMES) % 2) == 0;
      if (pix && !(c.attr.blink && !blink_on)) begin
        v.color = c.attr.fg;
      end else begin
        v.color = {1'b0, c.attr.bg};
      end
    end
    return v;
  endfunction

  // Reference raster stepped once per tick and checked 3 ticks late
  always @(negedge clk) begin
    if (!rst_n) begin
      mx     = 0;
      my     = 0;
      mframe = 0;
      exp_q  = {IDLE_VIDEO, IDLE_VIDEO, IDLE_VIDEO};
      full_q = {1'b0, 1'b0, 1'b0};
    end else if (pix_en) begin
      exp_q.push_back(expect_video(mx, my, mframe));
      full_q.push_back(mframe >= 2);
      exp_old  = exp_q.pop_front();
      full_old = full_q.pop_front();
      if (full_old) begin
        check_video(video, exp_old);
      end else begin
        check_sync(video.sync, exp_old.sync);
      end
      if (mx == H_TOT - 1) begin
        mx = 0;
        if (my == V_TOT - 1) begin
          my     = 0;
          mframe = mframe + 1;
        end else begin
          my = my + 1;
        end
      end else begin
        mx = mx + 1;
      end
    end
  end

  // Four-phase write with ack one cycle after each req change
  task automatic host_write(input logic sel, input logic [11:0] addr,
                            input txt_pkg::host_data_u data);
    int cycles;
    if (sel) begin
      font_mirror[addr] = data.font.bits;
    end else begin
      screen_mirror[addr] = data.scr_cell;
    end
    host_cmd = '{sel: sel, addr: addr, data: data};
    host_req = 1'b1;
    cycles   = 0;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end while (!host_ack && cycles < ACK_TIMEOUT);
    if (!host_ack) report_failure("timeout waiting for host_ack to rise");
    if (cycles != 1) report_failure("host_ack did not rise one cycle after host_req");
    host_req = 1'b0;
    cycles   = 0;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end while (host_ack && cycles < ACK_TIMEOUT);
    if (host_ack) report_failure("timeout waiting for host_ack to fall");
    if (cycles != 1) report_failure("host_ack did not fall one cycle after host_req dropped");
  endtask

  task automatic wait_for_line(input int frame, input int line);
    int cycles;
    cycles = 0;
    while (!(mframe == frame && my == line) && cycles < FRAME_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    if (!(mframe == frame && my == line)) begin
      report_failure("timeout waiting for the raster to reach the requested line");
    end
  endtask

  initial begin
    txt_pkg::host_data_u data;
    rst_n    = 1'b0;
    host_req = 1'b0;
    host_cmd = '0;
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    // Eight distinct codes with random glyph rows
    for (int g = 0; g < 8; g++) begin
      glyph_codes[g] = {3'(g), 5'($random(seed))};
      for (int r = 0; r < txt_pkg::CHAR_H; r++) begin
        data           = '0;
        data.font.bits = 8'($random(seed));
        host_write(1'b1, {glyph_codes[g], 4'(r)}, data);
      end
    end
    for (int c = 0; c < H_CHARS * V_CHARS; c++) begin
      data               = '0;
      data.scr_cell.code = glyph_codes[3'($random(seed))];
      data.scr_cell.attr = 8'($random(seed));
      if (c == 0) begin
        data.scr_cell.attr.blink = 1'b1;                        // Always one blinker
        data.scr_cell.attr.fg    = {1'b1, data.scr_cell.attr.bg};
      end
      host_write(1'b0, 12'(c), data);
    end

    // Rewrite one cell and one glyph row in each vertical blank
    for (int f = 2; f < N_FRAMES - 1; f++) begin
      wait_for_line(f, V_ACT);
      data               = '0;
      data.scr_cell.code = glyph_codes[3'($random(seed))];
      data.scr_cell.attr = 8'($random(seed));
      host_write(1'b0, {9'd0, 3'($random(seed))}, data);
      data           = '0;
      data.font.bits = 8'($random(seed));
      host_write(1'b1, {glyph_codes[3'($random(seed))], 4'($random(seed))}, data);
    end

    wait_for_line(N_FRAMES, 0);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/text_display.sv
////////////////////////////////////////////////////////////
// Text display top level
// Host port plus three-stage raster pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module text_display #(
  parameter int H_CHARS      = 80,         // 640x480 text screen
  parameter int V_CHARS      = 30,
  parameter int H_FRONT      = 16,
  parameter int H_SYNC       = 96,
  parameter int H_BACK       = 48,
  parameter int V_FRONT      = 10,
  parameter int V_SYNC       = 2,
  parameter int V_BACK       = 33,
  parameter int BLINK_FRAMES = 16
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 pix_en,
  input  wire                 host_req,
  input  txt_pkg::host_req_t  host_cmd,
  output logic                host_ack,
  output txt_pkg::video_t     video
);

  txt_pkg::cell_wr_t   cell_wr;
  txt_pkg::font_wr_t   font_wr;
  txt_pkg::raster_t    raster;
  txt_pkg::glyph_pix_t glyph_pix;

  host_port u_host_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_cmd (host_cmd),
    .host_ack (host_ack),
    .cell_wr  (cell_wr),
    .font_wr  (font_wr)
  );

  scan_decode #(
    .H_CHARS      (H_CHARS),
    .V_CHARS      (V_CHARS),
    .H_FRONT      (H_FRONT),
    .H_SYNC       (H_SYNC),
    .H_BACK       (H_BACK),
    .V_FRONT      (V_FRONT),
    .V_SYNC       (V_SYNC),
    .V_BACK       (V_BACK),
    .BLINK_FRAMES (BLINK_FRAMES)
  ) u_scan_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .pix_en  (pix_en),
    .cell_wr (cell_wr),
    .raster  (raster)
  );

  char_gen u_char_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_en    (pix_en),
    .font_wr   (font_wr),
    .raster    (raster),
    .glyph_pix (glyph_pix)
  );

  pixel_out u_pixel_out (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_en    (pix_en),
    .glyph_pix (glyph_pix),
    .video     (video)
  );

endmodule

`default_nettype wire

//--- hdl/pixel_out.sv
////////////////////////////////////////////////////////////
// Pixel output stage
// Blink, blank and fg/bg color select, registered video
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pixel_out (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  pix_en,
  input  txt_pkg::glyph_pix_t  glyph_pix,
  output txt_pkg::video_t      video
);

  logic       pix_on;
  logic [3:0] color_d;

  // Blinking cells hide their glyph in the off phase
  assign pix_on = glyph_pix.pixel && !(glyph_pix.attr.blink && !glyph_pix.blink_on);

  always_comb begin
    if (glyph_pix.sync.blank) begin
      color_d = 4'd0;
    end else if (pix_on) begin
      color_d = glyph_pix.attr.fg;
    end else begin
      color_d = {1'b0, glyph_pix.attr.bg};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      video <= '{color: 4'd0, sync: '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1}};
    end else if (pix_en) begin
      video.color <= color_d;
      video.sync  <= glyph_pix.sync;
    end
  end

endmodule

`default_nettype wire

//--- hdl/char_gen.sv
////////////////////////////////////////////////////////////
// Character generator
// Font memory lookup and pixel select for each tick
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module char_gen (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  pix_en,
  input  txt_pkg::font_wr_t    font_wr,
  input  txt_pkg::raster_t     raster,
  output txt_pkg::glyph_pix_t  glyph_pix
);

  logic [txt_pkg::FONT_AW-1:0] font_addr;
  logic [txt_pkg::CHAR_W-1:0]  row_q;
  logic [txt_pkg::COL_W-1:0]   col_q;
  txt_pkg::attr_t              attr_q;
  txt_pkg::sync_t              sync_q;
  logic                        blink_q;

  logic [txt_pkg::CHAR_W-1:0] font_mem [0:(1 << txt_pkg::FONT_AW)-1];

  assign font_addr = {raster.scr_cell.code, raster.glyph_row};

  // Host writes and raster reads on separate ports
  always_ff @(posedge clk) begin
    if (font_wr.en) begin
      font_mem[font_wr.addr] <= font_wr.bits;
    end
    if (pix_en) begin
      row_q  <= font_mem[font_addr];
      col_q  <= raster.glyph_col;
      attr_q <= raster.scr_cell.attr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q  <= '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
      blink_q <= 1'b1;
    end else if (pix_en) begin
      sync_q  <= raster.sync;
      blink_q <= raster.blink_on;
    end
  end

  always_comb begin
    glyph_pix.pixel    = row_q[~col_q];      // Column 0 is bit 7
    glyph_pix.attr     = attr_q;
    glyph_pix.sync     = sync_q;
    glyph_pix.blink_on = blink_q;
  end

endmodule

`default_nettype wire

//--- hdl/scan_decode.sv
////////////////////////////////////////////////////////////
// Raster scan and decode stage
// Pixel/line/frame counters, sync, blink and screen read
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module scan_decode #(
  parameter int H_CHARS      = 80,
  parameter int V_CHARS      = 30,
  parameter int H_FRONT      = 16,
  parameter int H_SYNC       = 96,
  parameter int H_BACK       = 48,
  parameter int V_FRONT      = 10,
  parameter int V_SYNC       = 2,
  parameter int V_BACK       = 33,
  parameter int BLINK_FRAMES = 16
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                pix_en,
  input  txt_pkg::cell_wr_t  cell_wr,
  output txt_pkg::raster_t   raster
);

  localparam int H_ACTIVE = H_CHARS * txt_pkg::CHAR_W;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_ACTIVE = V_CHARS * txt_pkg::CHAR_H;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int X_W      = $clog2(H_TOTAL);
  localparam int Y_W      = $clog2(V_TOTAL);
  localparam int F_W      = $clog2(BLINK_FRAMES + 1);

  logic [X_W-1:0] x;
  logic [Y_W-1:0] y;
  logic [F_W-1:0] frame_cnt;
  logic           blink_on;

  logic [txt_pkg::CELL_AW-1:0] cell_addr;
  txt_pkg::sync_t              sync_d;

  txt_pkg::cell_t                cell_q;
  logic [txt_pkg::ROW_W-1:0]     row_q;
  logic [txt_pkg::COL_W-1:0]     col_q;
  txt_pkg::sync_t                sync_q;
  logic                          blink_q;

  txt_pkg::cell_t screen_mem [0:(1 << txt_pkg::CELL_AW)-1];

  // Raster counters, y and frame move on x wrap
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x         <= '0;
      y         <= '0;
      frame_cnt <= '0;
      blink_on  <= 1'b1;
    end else if (pix_en) begin
      if (x == X_W'(H_TOTAL - 1)) begin
        x <= '0;
        if (y == Y_W'(V_TOTAL - 1)) begin
          y <= '0;
          if (frame_cnt == F_W'(BLINK_FRAMES - 1)) begin
            frame_cnt <= '0;
            blink_on  <= ~blink_on;
          end else begin
            frame_cnt <= frame_cnt + 1'b1;
          end
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  always_comb begin
    sync_d.hsync = (x >= X_W'(H_ACTIVE + H_FRONT)) &&
                   (x <  X_W'(H_ACTIVE + H_FRONT + H_SYNC));
    sync_d.vsync = (y >= Y_W'(V_ACTIVE + V_FRONT)) &&
                   (y <  Y_W'(V_ACTIVE + V_FRONT + V_SYNC));
    sync_d.blank = (x >= X_W'(H_ACTIVE)) || (y >= Y_W'(V_ACTIVE));
  end

  // Row of cells times line width plus column
  assign cell_addr = txt_pkg::CELL_AW'((y >> txt_pkg::ROW_W) * H_CHARS + (x >> txt_pkg::COL_W));

  // Screen memory, separate write and read ports
  always_ff @(posedge clk) begin
    if (cell_wr.en) begin
      screen_mem[cell_wr.addr] <= cell_wr.scr_cell;
    end
    if (pix_en) begin
      cell_q <= screen_mem[cell_addr];     // Old data on collision
      row_q  <= y[txt_pkg::ROW_W-1:0];
      col_q  <= x[txt_pkg::COL_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q  <= '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
      blink_q <= 1'b1;
    end else if (pix_en) begin
      sync_q  <= sync_d;
      blink_q <= blink_on;
    end
  end

  assign raster = '{scr_cell: cell_q, glyph_row: row_q, glyph_col: col_q,
                    sync: sync_q, blink_on: blink_q};

endmodule

`default_nettype wire

//--- hdl/host_port.sv
////////////////////////////////////////////////////////////
// Host port
// Four-phase req/ack slave issuing screen and font writes
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module host_port (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 host_req,
  input  txt_pkg::host_req_t  host_cmd,
  output logic                host_ack,
  output txt_pkg::cell_wr_t   cell_wr,
  output txt_pkg::font_wr_t   font_wr
);

  logic ack_q;
  logic wr_go;

  // New request seen, not yet acknowledged
  assign wr_go = host_req && !ack_q;

  // Ack follows req by one cycle in both directions
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= host_req;
    end
  end

  assign host_ack = ack_q;

  // Screen write, data word taken as a cell
  always_comb begin
    cell_wr.en       = wr_go && !host_cmd.sel;
    cell_wr.addr     = host_cmd.addr;
    cell_wr.scr_cell = host_cmd.data.scr_cell;
  end

  // Font write, data word taken as a glyph row
  always_comb begin
    font_wr.en   = wr_go && host_cmd.sel;
    font_wr.addr = host_cmd.addr;         // Code and row packed by host
    font_wr.bits = host_cmd.data.font.bits;
  end

endmodule

`default_nettype wire

//--- hdl/txt_pkg.sv
////////////////////////////////////////////////////////////
// Text display shared types
// Glyph geometry, cell and attribute layout, pipeline structs
////////////////////////////////////////////////////////////

`default_nettype none

package txt_pkg;

  localparam int CHAR_W  = 8;                // Glyph width in pixels
  localparam int CHAR_H  = 16;               // Glyph height in lines
  localparam int COL_W   = $clog2(CHAR_W);
  localparam int ROW_W   = $clog2(CHAR_H);
  localparam int CODE_W  = 8;
  localparam int CELL_AW = 12;               // Up to 4096 cells
  localparam int FONT_AW = CODE_W + ROW_W;   // Code times 16 plus row

  typedef struct packed {
    logic       blink;
    logic [2:0] bg;
    logic [3:0] fg;
  } attr_t;

  typedef struct packed {
    attr_t             attr;
    logic [CODE_W-1:0] code;
  } cell_t;

  typedef struct packed {
    logic [7:0]        unused;
    logic [CHAR_W-1:0] bits;                 // Bit 7 is the leftmost pixel
  } font_row_t;

  // One host word, seen as a screen cell or as a glyph row
  typedef union packed {
    cell_t     scr_cell;
    font_row_t font;
  } host_data_u;

  typedef struct packed {
    logic               sel;                 // 0 screen, 1 font
    logic [CELL_AW-1:0] addr;
    host_data_u         data;
  } host_req_t;

  typedef struct packed {
    logic               en;
    logic [CELL_AW-1:0] addr;
    cell_t              scr_cell;
  } cell_wr_t;

  typedef struct packed {
    logic               en;
    logic [FONT_AW-1:0] addr;
    logic [CHAR_W-1:0]  bits;
  } font_wr_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic blank;
  } sync_t;

  typedef struct packed {
    cell_t            scr_cell;
    logic [ROW_W-1:0] glyph_row;
    logic [COL_W-1:0] glyph_col;
    sync_t            sync;
    logic             blink_on;
  } raster_t;

  typedef struct packed {
    logic  pixel;
    attr_t attr;
    sync_t sync;
    logic  blink_on;
  } glyph_pix_t;

  typedef struct packed {
    logic [3:0] color;
    sync_t      sync;
  } video_t;

endpackage

`default_nettype wire
